//--- flist.f
+incdir+include
verilog/arch_defs_pkg.sv
verilog/alu.sv
verilog/word_store.sv
verilog/program_counter.sv
verilog/control_fsm.sv
verilog/cpu_top.sv
bench/clock_gen.sv
bench/tb_cpu.sv

//--- Bender.yml
package:
  name: reg_cpu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/arch_defs_pkg.sv
      - verilog/alu.sv
      - verilog/word_store.sv
      - verilog/program_counter.sv
      - verilog/control_fsm.sv
      - verilog/cpu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/clock_gen.sv
      - bench/tb_cpu.sv

//--- bench/tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_cpu;
    import arch_defs_pkg::*;

    typedef logic [`DATA_WIDTH:0] wide_t;

    // one expected out pulse.
    typedef struct packed {
        data_t  data;
        flags_t flags;
    } out_rec_t;

    logic                        clk;
    logic                        reset;
    logic                        reset_req = 1'b0;
    logic                        start     = 1'b0;
    logic                        load_we   = 1'b0;
    logic [`PROG_ADDR_WIDTH-1:0] load_addr = '0;
    instr_t                      load_data = '0;
    logic                        out_valid;
    data_t                       out_data;
    flags_t                      out_flags;
    logic                        done;
    logic                        busy;

    instr_t   prog [`PROG_DEPTH];
    data_t    model_regs [`REG_COUNT] = '{default: '0};
    flags_t   model_flags = '0;
    out_rec_t exp_q [$];
    string    test_name  = "reset";
    int       done_count = 0;
    int       cycles     = 0;
    int       wd_start   = 0;
    int       wd_limit   = 40;

    clock_gen i_clk_gen (
        .reset_req_i (reset_req),
        .clk_o       (clk),
        .reset_o     (reset)
    );

    cpu_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .start_i     (start),
        .load_we_i   (load_we),
        .load_addr_i (load_addr),
        .load_data_i (load_data),
        .out_valid_o (out_valid),
        .out_data_o  (out_data),
        .out_flags_o (out_flags),
        .done_o      (done),
        .busy_o      (busy)
    );

    function automatic instr_t ldi(int rd, data_t imm);
        return '{cls: CLS_LDI, op: ALU_ADD, rd: rd[`REG_ADDR_WIDTH-1:0], rs: '0, imm: imm};
    endfunction

    function automatic instr_t alu_r(alu_op_t op, int rd, int rs);
        return '{cls: CLS_ALU_R, op: op, rd: rd[`REG_ADDR_WIDTH-1:0],
                 rs: rs[`REG_ADDR_WIDTH-1:0], imm: '0};
    endfunction

    function automatic instr_t alu_i(alu_op_t op, int rd, data_t imm);
        return '{cls: CLS_ALU_I, op: op, rd: rd[`REG_ADDR_WIDTH-1:0], rs: '0, imm: imm};
    endfunction

    function automatic instr_t jump(instr_class_t cls, int target);
        return '{cls: cls, op: ALU_ADD, rd: '0, rs: '0, imm: data_t'(target)};
    endfunction

    function automatic instr_t out_reg(int rd);
        return '{cls: CLS_OUT, op: ALU_ADD, rd: rd[`REG_ADDR_WIDTH-1:0], rs: '0, imm: '0};
    endfunction

    function automatic instr_t halt();
        return '{cls: CLS_HLT, op: ALU_ADD, rd: '0, rs: '0, imm: '0};
    endfunction

    function automatic void stop_with_error(string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "run stopped at the first error");
    endfunction

    // result and flags straight from the architecture rules.
    function automatic out_rec_t model_alu(alu_op_t op, data_t a, data_t b, logic cin);
        wide_t    wide;
        out_rec_t r;
        case (op)
            ALU_ADD: wide = wide_t'(a) + wide_t'(b);
            ALU_ADC: wide = wide_t'(a) + wide_t'(b) + wide_t'(cin);
            ALU_SUB: wide = {a >= b, a - b}; // carry set means no borrow.
            ALU_INR: wide = {a == '1, a + 1'b1};
            ALU_DCR: wide = {a != '0, a - 1'b1};
            ALU_AND: wide = {1'b0, a & b};
            ALU_OR:  wide = {1'b0, a | b};
            default: wide = 'x;
        endcase
        r.data  = wide[`DATA_WIDTH-1:0];
        r.flags = '{zero: (r.data == '0), carry: wide[`DATA_WIDTH],
                    negative: wide[`DATA_WIDTH-1]};
        return r;
    endfunction

    // runs prog on the register model and queues every out.
    function automatic void model_run(int step_limit);
        int       pc;
        instr_t   w;
        out_rec_t r;
        pc = 0;
        for (int step = 0; step < step_limit; step++) begin
            w  = prog[pc];
            pc = (pc + 1) % `PROG_DEPTH;
            case (w.cls)
                CLS_ALU_R, CLS_ALU_I: begin
                    r = model_alu(w.op, model_regs[w.rd],
                                  (w.cls == CLS_ALU_I) ? w.imm : model_regs[w.rs],
                                  model_flags.carry);
                    model_regs[w.rd] = r.data;
                    model_flags      = r.flags;
                end
                CLS_LDI: model_regs[w.rd] = w.imm;
                CLS_JZ:  if (model_flags.zero) pc = int'(w.imm[`PROG_ADDR_WIDTH-1:0]);
                CLS_JC:  if (model_flags.carry) pc = int'(w.imm[`PROG_ADDR_WIDTH-1:0]);
                CLS_JMP: pc = int'(w.imm[`PROG_ADDR_WIDTH-1:0]);
                CLS_OUT: exp_q.push_back(out_rec_t'{data: model_regs[w.rd], flags: model_flags});
                CLS_HLT: return;
            endcase
        end
        stop_with_error($sformatf("%s: program did not halt within %0d steps",
                                  test_name, step_limit));
    endfunction

    task automatic check_data(string what, data_t exp, data_t act);
        if (act !== exp) begin
            stop_with_error($sformatf("FAIL %s %s expected 0x%02h actual 0x%02h",
                                      test_name, what, exp, act));
        end
    endtask

    task automatic check_flags(string what, flags_t exp, flags_t act);
        if (act !== exp) begin
            stop_with_error($sformatf("FAIL %s %s expected zcn=%03b actual zcn=%03b",
                                      test_name, what, exp, act));
        end
    endtask

    // every out pulse is checked against the head of the queue.
    always @(negedge clk) begin
        if (!reset && out_valid) begin
            if (exp_q.size() == 0) begin
                stop_with_error($sformatf("%s: the DUT gave an output nobody expected",
                                          test_name));
            end else begin
                check_data("out_data", exp_q[0].data, out_data);
                check_flags("out_flags", exp_q[0].flags, out_flags);
                void'(exp_q.pop_front());
            end
        end
        if (!reset && done) begin
            done_count++;
            if (exp_q.size() != 0) begin
                stop_with_error($sformatf("%s: halted with %0d outputs still missing",
                                          test_name, exp_q.size()));
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles - wd_start > wd_limit) begin
            stop_with_error($sformatf("%s: watchdog expired after %0d cycles",
                                      test_name, wd_limit));
        end
    end

    task automatic arm_watchdog(int budget);
        wd_start = cycles;
        wd_limit = budget;
    endtask

    task automatic load_program();
        arm_watchdog(`PROG_DEPTH + 10);
        for (int a = 0; a < `PROG_DEPTH; a++) begin
            @(posedge clk);
            load_we   <= 1'b1;
            load_addr <= a[`PROG_ADDR_WIDTH-1:0];
            load_data <= prog[a];
        end
        @(posedge clk);
        load_we <= 1'b0;
    endtask

    // start pulse and wait for the halt with optional writes while running.
    task automatic run_program(int step_limit, bit tamper);
        int seen;
        seen = done_count;
        model_run(step_limit);
        arm_watchdog(3 * step_limit + 20);
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        if (tamper) begin
            for (int a = 0; a < 3; a++) begin
                @(posedge clk);
                load_we   <= 1'b1;
                load_addr <= a[`PROG_ADDR_WIDTH-1:0];
                load_data <= ldi(3, 8'hee);
                @(negedge clk);
                if (!busy) begin
                    stop_with_error("busy_o dropped before the gated load writes ended");
                end
            end
            @(posedge clk);
            load_we <= 1'b0;
        end
        while (done_count == seen) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);
        if (done_count != seen + 1) begin
            stop_with_error($sformatf("%s: done_o pulsed %0d times in one run",
                                      test_name, done_count - seen));
        end
        if (busy) begin
            stop_with_error("busy_o is still high after the program halted");
        end
    endtask

    task automatic check_idle(int cycles_n);
        arm_watchdog(cycles_n + 30);
        @(negedge clk);
        while (reset) begin
            @(negedge clk);
        end
        repeat (cycles_n) begin
            @(negedge clk);
            if (out_valid || done || busy) begin
                stop_with_error("a strobe or busy_o is high after reset before any start");
            end
        end
    endtask

    task automatic reset_dut();
        @(posedge clk);
        reset_req <= 1'b1;
        @(posedge clk);
        reset_req <= 1'b0;
        @(negedge clk);
        model_regs  = '{default: '0};
        model_flags = '0;
    endtask

    initial begin
        data_t       a;
        data_t       b;
        data_t       c;
        data_t       d;
        logic [15:0] x;
        logic [15:0] y;
        int          n;
        void'($urandom(32'haa0e429f));
        check_idle(5);

        test_name = "arith";
        for (int r = 0; r < 8; r++) begin
            a = data_t'($urandom);
            b = data_t'($urandom);
            c = data_t'($urandom);
            if (r == 0) begin
                a = 8'h80; // zero results with carry out.
                b = 8'h80;
                c = 8'h01;
            end else if (r == 1) begin
                a = 8'h10; // borrow, inr and dcr wrap.
                b = 8'hff;
                c = 8'h00;
            end
            prog = '{ldi(0, a), ldi(1, b), alu_r(ALU_ADD, 0, 1), out_reg(0),
                     ldi(2, a), alu_r(ALU_SUB, 2, 1), out_reg(2), alu_r(ALU_INR, 1, 0),
                     out_reg(1), ldi(3, c), alu_r(ALU_DCR, 3, 0), out_reg(3),
                     halt(), halt(), halt(), halt()};
            load_program();
            run_program(16, 1'b0);
        end

        test_name = "carry_chain";
        for (int r = 0; r < 6; r++) begin
            x = 16'($urandom);
            y = 16'($urandom);
            case (r)
                0: begin
                    x = 16'hffff;
                    y = 16'h0001;
                end
                1: begin
                    x = 16'h00ff;
                    y = 16'h0001;
                end
                2: begin
                    x = 16'h8000;
                    y = 16'h8000;
                end
                default: ;
            endcase
            prog = '{ldi(0, x[7:0]), ldi(1, x[15:8]), ldi(2, y[7:0]), ldi(3, y[15:8]),
                     alu_r(ALU_ADD, 0, 2), alu_r(ALU_ADC, 1, 3), out_reg(0), out_reg(1),
                     halt(), halt(), halt(), halt(), halt(), halt(), halt(), halt()};
            load_program();
            run_program(16, 1'b0);
        end

        test_name = "logic";
        for (int r = 0; r < 6; r++) begin
            a = (r == 0) ? 8'hf0 : data_t'($urandom);
            b = (r == 0) ? 8'h0f : data_t'($urandom);
            c = (r == 0) ? 8'h00 : data_t'($urandom);
            d = (r == 0) ? 8'h00 : data_t'($urandom);
            // the inr wrap leaves carry set before the logic ops.
            prog = '{ldi(3, 8'hff), alu_r(ALU_INR, 3, 0), ldi(0, a), ldi(1, b),
                     alu_r(ALU_AND, 0, 1), out_reg(0), ldi(2, a), alu_r(ALU_OR, 2, 1),
                     out_reg(2), alu_i(ALU_AND, 1, c), out_reg(1), alu_i(ALU_OR, 1, d),
                     out_reg(1), halt(), halt(), halt()};
            load_program();
            run_program(16, 1'b0);
        end

        test_name = "control_flow";
        for (int r = 0; r < 3; r++) begin
            n = 1 + int'($urandom % 6);
            prog = '{ldi(0, data_t'(n)), ldi(1, 8'h00), out_reg(0), alu_r(ALU_INR, 1, 0),
                     alu_r(ALU_DCR, 0, 0), jump(CLS_JZ, 7), jump(CLS_JMP, 2), out_reg(1),
                     ldi(2, 8'hf0), alu_i(ALU_ADD, 2, 8'h20), jump(CLS_JC, 12), out_reg(2),
                     alu_i(ALU_SUB, 2, 8'h20), jump(CLS_JC, 15), out_reg(2), halt()};
            load_program();
            run_program(64, 1'b0);
        end

        test_name = "restart";
        a = data_t'($urandom);
        prog = '{alu_r(ALU_INR, 0, 0), out_reg(0), ldi(1, a), out_reg(1),
                 alu_r(ALU_ADD, 0, 1), out_reg(0), halt(), halt(),
                 halt(), halt(), halt(), halt(), halt(), halt(), halt(), halt()};
        load_program();
        run_program(16, 1'b1);
        run_program(16, 1'b0); // registers carry over between runs.
        prog[2] = ldi(1, a ^ 8'h3c);
        load_program(); // accepted while halted.
        run_program(16, 1'b0);

        test_name = "post_reset";
        reset_dut();
        check_idle(10);
        load_program();
        run_program(16, 1'b0);

        if (exp_q.size() != 0) begin
            stop_with_error("expected outputs are left over at the end of the run");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

//--- bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 10
) (
    input  logic reset_req_i,
    output logic clk_o,
    output logic reset_o
);

    logic clk      = 1'b0;
    int   hold_cnt = RESET_CYCLES; // edges left with reset high.

    always #(PERIOD_NS / 2) clk = ~clk;

    always @(posedge clk) begin
        if (reset_req_i) begin
            hold_cnt <= RESET_CYCLES; // restart the reset window.
        end else if (hold_cnt != 0) begin
            hold_cnt <= hold_cnt - 1;
        end
    end

    assign clk_o   = clk;
    assign reset_o = (hold_cnt != 0);

endmodule

//--- verilog/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start_i,
    input  logic                        load_we_i,
    input  logic [`PROG_ADDR_WIDTH-1:0] load_addr_i,
    input  arch_defs_pkg::instr_t       load_data_i,
    output logic                        out_valid_o,
    output arch_defs_pkg::data_t        out_data_o,
    output arch_defs_pkg::flags_t       out_flags_o,
    output logic                        done_o,
    output logic                        busy_o
);
    import arch_defs_pkg::*;

    instr_t                      prog_word;   // word at the current pc.
    data_t                       rd_data;
    data_t                       rs_data;
    data_t                       latched_result;
    data_t                       reg_wdata;
    alu_op_t                     alu_op;
    logic                        alu_zero;
    logic                        alu_carry;
    logic                        alu_negative;
    logic                        use_imm;
    logic                        carry_in;
    logic                        pc_clear;
    logic                        pc_inc;
    logic                        pc_load;
    logic                        reg_we;
    logic                        load_allowed;
    logic [`PROG_ADDR_WIDTH-1:0] pc;
    logic [`PROG_ADDR_WIDTH-1:0] jump_addr;
    logic [`REG_ADDR_WIDTH-1:0]  reg_waddr;

    word_store #(
        .entry_t (instr_t),
        .DEPTH   (`PROG_DEPTH)
    ) i_prog_mem (
        .clk       (clk),
        .reset     (reset),
        .we_i      (load_we_i && load_allowed), // loads only while stopped.
        .waddr_i   (load_addr_i),
        .wdata_i   (load_data_i),
        .raddr_a_i (pc),
        .rdata_a_o (prog_word),
        .raddr_b_i ('0),
        .rdata_b_o ()
    );

    // pc still points at the current word through exec.
    word_store #(
        .entry_t (data_t),
        .DEPTH   (`REG_COUNT)
    ) i_reg_file (
        .clk       (clk),
        .reset     (reset),
        .we_i      (reg_we),
        .waddr_i   (reg_waddr),
        .wdata_i   (reg_wdata),
        .raddr_a_i (prog_word.rd),
        .rdata_a_o (rd_data),
        .raddr_b_i (prog_word.rs),
        .rdata_b_o (rs_data)
    );

    program_counter #(
        .ADDR_WIDTH (`PROG_ADDR_WIDTH)
    ) i_pc (
        .clk         (clk),
        .reset       (reset),
        .clear_i     (pc_clear),
        .inc_i       (pc_inc),
        .load_i      (pc_load),
        .load_addr_i (jump_addr),
        .pc_o        (pc)
    );

    control_fsm i_ctrl (
        .clk              (clk),
        .reset            (reset),
        .start_i          (start_i),
        .instr_i          (prog_word),
        .rd_data_i        (rd_data),
        .latched_result_i (latched_result),
        .zero_i           (alu_zero),
        .carry_i          (alu_carry),
        .negative_i       (alu_negative),
        .alu_op_o         (alu_op),
        .use_imm_o        (use_imm),
        .carry_in_o       (carry_in),
        .pc_clear_o       (pc_clear),
        .pc_inc_o         (pc_inc),
        .pc_load_o        (pc_load),
        .jump_addr_o      (jump_addr),
        .reg_we_o         (reg_we),
        .reg_waddr_o      (reg_waddr),
        .reg_wdata_o      (reg_wdata),
        .load_allowed_o   (load_allowed),
        .out_valid_o      (out_valid_o),
        .out_data_o       (out_data_o),
        .out_flags_o      (out_flags_o),
        .done_o           (done_o),
        .busy_o           (busy_o)
    );

    alu i_alu (
        .clk            (clk),
        .reset          (reset),
        .in_one         (rd_data),
        .in_two         (use_imm ? prog_word.imm : rs_data), // imm form selects the literal.
        .in_carry       (carry_in),
        .alu_op         (alu_op),
        .latched_result (latched_result),
        .zero_flag      (alu_zero),
        .carry_flag     (alu_carry),
        .negative_flag  (alu_negative)
    );

endmodule

//--- verilog/control_fsm.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module control_fsm (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start_i,
    input  arch_defs_pkg::instr_t       instr_i,
    input  arch_defs_pkg::data_t        rd_data_i,
    input  arch_defs_pkg::data_t        latched_result_i,
    input  logic                        zero_i,
    input  logic                        carry_i,
    input  logic                        negative_i,
    output arch_defs_pkg::alu_op_t      alu_op_o,
    output logic                        use_imm_o,
    output logic                        carry_in_o,
    output logic                        pc_clear_o,
    output logic                        pc_inc_o,
    output logic                        pc_load_o,
    output logic [`PROG_ADDR_WIDTH-1:0] jump_addr_o,
    output logic                        reg_we_o,
    output logic [`REG_ADDR_WIDTH-1:0]  reg_waddr_o,
    output arch_defs_pkg::data_t        reg_wdata_o,
    output logic                        load_allowed_o,
    output logic                        out_valid_o,
    output arch_defs_pkg::data_t        out_data_o,
    output arch_defs_pkg::flags_t       out_flags_o,
    output logic                        done_o,
    output logic                        busy_o
);
    import arch_defs_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_EXEC,
        S_WRITE,
        S_HALTED
    } state_t;

    state_t state;
    state_t state_next;
    instr_t ir;       // instruction register.
    flags_t flags;    // stored zero, carry, negative.
    logic   done_q;
    logic   in_exec;
    logic   is_alu;
    logic   take_jump;
    logic   can_start;

    assign in_exec   = (state == S_EXEC);
    assign is_alu    = (ir.cls == CLS_ALU_R) || (ir.cls == CLS_ALU_I);
    assign can_start = (state == S_IDLE) || (state == S_HALTED);

    // jumps test the stored flags, not the live alu ones.
    always_comb begin
        case (ir.cls)
            CLS_JZ:  take_jump = flags.zero;
            CLS_JC:  take_jump = flags.carry;
            CLS_JMP: take_jump = 1'b1;
            default: take_jump = 1'b0;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE:   if (start_i) state_next = S_FETCH;
            S_FETCH:  state_next = S_EXEC;
            S_EXEC:   state_next = (ir.cls == CLS_HLT) ? S_HALTED : S_WRITE;
            S_WRITE:  state_next = S_FETCH;
            S_HALTED: if (start_i) state_next = S_FETCH;
            default:  state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= S_IDLE;
            ir     <= '0;
            flags  <= '0;
            done_q <= 1'b0;
        end else begin
            state  <= state_next;
            done_q <= in_exec && (ir.cls == CLS_HLT); // high in first halted cycle.
            if (state == S_FETCH) begin
                ir <= instr_i;
            end
            if (in_exec && is_alu) begin
                flags <= '{zero: zero_i, carry: carry_i, negative: negative_i};
            end
        end
    end

    // operand and alu control, op held at add outside alu execution.
    assign alu_op_o   = (in_exec && is_alu) ? ir.op : ALU_ADD;
    assign use_imm_o  = (ir.cls == CLS_ALU_I);
    assign carry_in_o = flags.carry;

    assign pc_clear_o  = start_i && can_start;
    assign pc_load_o   = in_exec && take_jump;
    assign pc_inc_o    = in_exec && !take_jump;
    assign jump_addr_o = ir.imm[`PROG_ADDR_WIDTH-1:0];

    // write-back in the third cycle.
    assign reg_we_o    = (state == S_WRITE) && (is_alu || (ir.cls == CLS_LDI));
    assign reg_waddr_o = ir.rd;
    assign reg_wdata_o = (ir.cls == CLS_LDI) ? ir.imm : latched_result_i;

    assign load_allowed_o = can_start;
    assign out_valid_o    = in_exec && (ir.cls == CLS_OUT);
    assign out_data_o     = rd_data_i;
    assign out_flags_o    = flags;
    assign done_o         = done_q;
    assign busy_o         = (state == S_FETCH) || in_exec || (state == S_WRITE);

    // out strobes in exec, done only once halted.
    a_out_done_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(out_valid_o && done_o)
    );

endmodule

//--- verilog/program_counter.sv
`timescale 1ns/1ps

module program_counter #(
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clear_i,
    input  logic                  inc_i,
    input  logic                  load_i,
    input  logic [ADDR_WIDTH-1:0] load_addr_i,
    output logic [ADDR_WIDTH-1:0] pc_o
);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_o <= '0;
        end else if (clear_i) begin
            pc_o <= '0; // restart from address 0.
        end else if (load_i) begin
            pc_o <= load_addr_i;
        end else if (inc_i) begin
            pc_o <= pc_o + 1'b1; // wraps at depth.
        end
    end

    // a taken jump replaces the increment, never both.
    a_inc_load_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(inc_i && load_i)
    );

endmodule

//--- verilog/word_store.sv
`timescale 1ns/1ps

module word_store #(
    parameter type entry_t  = logic [7:0],
    parameter int  DEPTH    = 4,
    localparam int AW       = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          we_i,
    input  logic [AW-1:0] waddr_i,
    input  entry_t        wdata_i,
    input  logic [AW-1:0] raddr_a_i,
    output entry_t        rdata_a_o,
    input  logic [AW-1:0] raddr_b_i,
    output entry_t        rdata_b_o
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // read ports are asynchronous.
    assign rdata_a_o = mem[raddr_a_i];
    assign rdata_b_o = mem[raddr_b_i];

    a_waddr_in_range: assert property (
        @(posedge clk) disable iff (reset)
        we_i |-> (!$isunknown(waddr_i) && (int'(waddr_i) < DEPTH))
    );

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps
`include "cpu_settings.svh"

module alu (
    input  logic                   clk,
    input  logic                   reset,
    input  arch_defs_pkg::data_t   in_one,
    input  arch_defs_pkg::data_t   in_two,
    input  logic                   in_carry,
    input  arch_defs_pkg::alu_op_t alu_op,
    output arch_defs_pkg::data_t   latched_result,
    output logic                   zero_flag,
    output logic                   carry_flag,
    output logic                   negative_flag
);
    import arch_defs_pkg::*;

    logic [`DATA_WIDTH:0] arith_sum; // extra bit holds the carry out.
    data_t                logic_res;
    data_t                result;
    logic                 carry_out;

    always_comb begin
        arith_sum = '0;
        logic_res = '0;
        case (alu_op)
            ALU_ADD: arith_sum = {1'b0, in_one} + {1'b0, in_two};
            ALU_ADC: arith_sum = {1'b0, in_one} + {1'b0, in_two}
                                 + {{`DATA_WIDTH{1'b0}}, in_carry};
            // subtract as a + ~b + 1, so carry 1 means no borrow.
            ALU_SUB: arith_sum = {1'b0, in_one} + {1'b0, ~in_two}
                                 + {{`DATA_WIDTH{1'b0}}, 1'b1};
            ALU_INR: arith_sum = {1'b0, in_one} + {{`DATA_WIDTH{1'b0}}, 1'b1};
            ALU_DCR: arith_sum = {1'b0, in_one} + {1'b0, {`DATA_WIDTH{1'b1}}}; // a + 0xff.
            ALU_AND: logic_res = in_one & in_two;
            ALU_OR:  logic_res = in_one | in_two;
            default: logic_res = '0;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_ADD, ALU_ADC, ALU_SUB, ALU_INR, ALU_DCR: begin
                result    = arith_sum[`DATA_WIDTH-1:0];
                carry_out = arith_sum[`DATA_WIDTH];
            end
            default: begin
                result    = logic_res;
                carry_out = 1'b0; // logic ops clear carry.
            end
        endcase
    end

    assign carry_flag    = carry_out;
    assign zero_flag     = (result == '0);
    assign negative_flag = result[`DATA_WIDTH-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            latched_result <= '0;
        end else begin
            latched_result <= result;
        end
    end

    // the fsm parks the op at add outside alu execution, so a known
    // reserved code means an alu-class word carried a bad op field.
    a_no_reserved_op: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(alu_op) |-> (alu_op != alu_op_t'(3'd7))
    );

endmodule

//--- verilog/arch_defs_pkg.sv
`include "cpu_settings.svh"

package arch_defs_pkg;

    typedef logic [`DATA_WIDTH-1:0] data_t;

    // alu operation codes, 3'd7 stays reserved.
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_ADC = 3'd1, // add with stored carry.
        ALU_SUB = 3'd2,
        ALU_INR = 3'd3,
        ALU_DCR = 3'd4,
        ALU_AND = 3'd5,
        ALU_OR  = 3'd6
    } alu_op_t;

    typedef enum logic [2:0] {
        CLS_ALU_R = 3'd0, // rd = rd op rs.
        CLS_ALU_I = 3'd1, // rd = rd op imm.
        CLS_LDI   = 3'd2, // rd = imm.
        CLS_JZ    = 3'd3, // jump when zero flag set.
        CLS_JC    = 3'd4, // jump when carry flag set.
        CLS_JMP   = 3'd5,
        CLS_OUT   = 3'd6, // present rd on the output port.
        CLS_HLT   = 3'd7
    } instr_class_t;

    // 18-bit instruction word, class in the top bits.
    typedef struct packed {
        instr_class_t               cls;
        alu_op_t                    op;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        data_t                      imm;
    } instr_t;

    typedef struct packed {
        logic zero;
        logic carry;
        logic negative;
    } flags_t;

endpackage

//--- include/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath width in bits.
`define DATA_WIDTH 8

// general purpose registers and the width of their index.
`define REG_COUNT 4
`define REG_ADDR_WIDTH 2

// program memory depth in instruction words.
`define PROG_DEPTH 16
`define PROG_ADDR_WIDTH 4

`endif
